/* verification/control_unit_vectors.txt */
# name inst rs_data rt_data pc_plus4 | alu_op exc wreg wmem result_sel alusrc1 regdst sign
# load_type store_type pc_target_sel pc_branch (all values hex)
sync_nop 0000000f 00000000 00000000 00400004 00 0 0 0 0 0 0 1 0 0 0 00000000
addu 00221821 00000003 00000004 00400008 02 0 1 0 1 0 1 1 0 0 0 00000000
slt 00a6202a ffffffff 00000001 0040000c 09 0 1 0 1 0 1 1 0 0 0 00000000
sra_shamt 000838c3 00000000 80000000 00400010 0d 0 1 0 1 0 1 1 0 0 0 00000000
ori 35491234 0000ff00 00000000 00400014 16 0 1 0 1 3 0 0 0 0 0 00000000
lui 3c0babcd 00000000 00000000 00400018 18 0 1 0 1 3 0 0 0 0 0 00000000
lw 8dac0008 10000000 00000000 0040001c 1d 0 1 0 2 3 0 1 5 0 0 00000000
lbu_neg_off 91eeffff 10000010 00000000 00400020 1a 0 1 0 2 3 0 1 2 0 0 00000000
sw acc50004 10000000 12345678 00400024 20 0 0 1 0 3 0 1 0 3 0 00000000
sb a1070000 10000004 000000ab 00400028 1e 0 0 1 0 3 0 1 0 1 0 00000000
beq_taken 10220004 00000005 00000005 00400010 00 0 0 0 0 0 0 1 0 0 1 00400020
beq_not_taken 10220004 00000005 00000006 00400010 00 0 0 0 0 0 0 1 0 0 0 00400020
bne_taken_back 1464fffc 00000001 00000002 00400100 00 0 0 0 0 0 0 1 0 0 1 004000f0
bne_not_taken 1464fffc 00000007 00000007 00400100 00 0 0 0 0 0 0 1 0 0 0 004000f0
bltz_taken 04a00010 80000000 00000000 00401000 00 0 0 0 0 0 0 1 0 0 1 00401040
bltz_not_taken 04a00010 00000001 00000000 00401000 00 0 0 0 0 0 0 1 0 0 0 00401040
bgez_taken 04a10010 00000000 00000000 00401000 00 0 0 0 0 0 0 1 0 0 1 00401040
bgez_not_taken 04a10010 ffffffff 00000000 00401000 00 0 0 0 0 0 0 1 0 0 0 00401040
j 08100040 00000000 00000000 90000004 00 0 0 0 0 0 0 1 0 0 1 90400100
jal 0c100040 00000000 00000000 00400008 21 0 1 0 1 0 2 1 0 0 1 00400100
jr 03e00008 00400200 00000000 00400030 00 0 0 0 0 0 0 1 0 0 1 00400200
jalr 0080f809 00412340 00000000 00400034 21 0 1 0 1 0 1 1 0 0 1 00412340
syscall 0000000c 00000000 00000000 00400038 00 4 0 0 0 0 0 1 0 0 0 00000000
break 0000000d 00000000 00000000 0040003c 00 2 0 0 0 0 0 1 0 0 0 00000000
cop1 44000000 00000000 00000000 00400040 00 1 0 0 0 0 0 1 0 0 0 00000000
mult_dropped 00220018 00000002 00000003 00400044 00 8 0 0 0 0 0 1 0 0 0 00000000
lui_rs_nonzero 3c2babcd 00000000 00000000 00400048 18 8 1 0 1 3 0 0 0 0 0 00000000

/* verilog.f */
hdl/mips_decode_pkg.sv
hdl/alu_op_decoder.sv
hdl/datapath_ctrl_decoder.sv
hdl/branch_unit.sv
hdl/decode_stage_reg.sv
hdl/control_unit.sv
verification/tb_control_unit.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f verilog.f --top-module tb_control_unit \
		-Mdir obj_dir -o sim_control_unit

run: compile
	./obj_dir/sim_control_unit > sim.log 2>&1; cat sim.log
	@if grep -q "sim failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* verification/tb_control_unit.sv */
`timescale 1ns/1ns

module tb_control_unit;
	import mips_decode_pkg::*;

	localparam int MAX_VEC = 64;
	localparam int NCOL = 16;

	logic clk;
	logic rst_n;
	logic [XLEN-1:0] inst;
	logic [XLEN-1:0] rs_data;
	logic [XLEN-1:0] rt_data;
	logic [XLEN-1:0] pc_plus4;

	alu_op_e         o_alu_op;
	exc_flags_t      o_exc;
	logic            o_wreg;
	logic            o_wmem;
	result_sel_e     o_result_sel;
	logic            o_alusrc0_sel;
	alusrc1_sel_e    o_alusrc1_sel;
	regdst_e         o_regdst;
	logic            o_sign;
	load_type_e      o_load_type;
	store_type_e     o_store_type;
	logic            o_i_bj;
	logic            o_i_b;
	logic            o_pc_target_sel;
	logic [XLEN-1:0] o_pc_branch;

	// one row per test in vector file column order
	logic [127:0] names [0:MAX_VEC-1];
	logic [31:0]  vecs [0:MAX_VEC-1][0:NCOL-1];
	logic [127:0] cur_name;
	int n_vec;
	int pass_count;
	int fail_count;
	int test_errs;
	int cycles;
	int cycle_limit;
	bit load_ok;

	control_unit DUT (
		.clk(clk), .rst_n(rst_n), .i_inst(inst), .i_rs_data(rs_data),
		.i_rt_data(rt_data), .i_pc_plus4(pc_plus4),
		.o_alu_op(o_alu_op), .o_exc(o_exc), .o_wreg(o_wreg), .o_wmem(o_wmem),
		.o_result_sel(o_result_sel), .o_alusrc0_sel(o_alusrc0_sel),
		.o_alusrc1_sel(o_alusrc1_sel), .o_regdst(o_regdst), .o_sign(o_sign),
		.o_load_type(o_load_type), .o_store_type(o_store_type), .o_i_bj(o_i_bj),
		.o_i_b(o_i_b), .o_pc_target_sel(o_pc_target_sel), .o_pc_branch(o_pc_branch)
	);

	always #2 clk = ~clk;

	// guard against a stuck run
	always @(posedge clk)
		begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
			begin
			$display("timeout: the run reached %0d cycles before all tests finished", cycles);
			$display("sim failed");
			$finish;
			end
		end

	task automatic load_vectors(output int count, output bit ok);
		int fd;
		int n;
		int r;
		string line;
		count = 0;
		ok = 1'b1;
		fd = $fopen("verification/control_unit_vectors.txt", "r");
		if (fd == 0)
			begin
			$display("cannot open the vector file verification/control_unit_vectors.txt");
			ok = 1'b0;
			end
		else
			begin
			while (!$feof(fd) && count < MAX_VEC)
				begin
				r = $fgets(line, fd);
				// skip blank and comment lines
				if (r > 0 && line.len() > 1 && line.getc(0) != 8'h23)
					begin
					n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						names[count], vecs[count][0], vecs[count][1], vecs[count][2],
						vecs[count][3], vecs[count][4], vecs[count][5], vecs[count][6],
						vecs[count][7], vecs[count][8], vecs[count][9], vecs[count][10],
						vecs[count][11], vecs[count][12], vecs[count][13], vecs[count][14],
						vecs[count][15]);
					if (n == NCOL + 1)
						count = count + 1;
					else
						begin
						$display("malformed line in the vector file: %s", line);
						ok = 1'b0;
						end
					end
				end
			$fclose(fd);
			end
	endtask

	task automatic compare_field(input string field, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (act_val !== exp_val)
			begin
			test_errs = test_errs + 1;
			$display("[FAIL] %0s %0s expected %h actual %h", cur_name, field, exp_val, act_val);
			end
	endtask

	task automatic close_test();
		if (test_errs == 0)
			begin
			pass_count = pass_count + 1;
			$display("[PASS] %0s", cur_name);
			end
		else
			begin
			fail_count = fail_count + 1;
			$display("[FAIL] %0s with %0d wrong field(s)", cur_name, test_errs);
			end
	endtask

	// reset must mask the jal held at the inputs
	task automatic check_reset();
		cur_name = "reset";
		test_errs = 0;
		repeat (5)
			begin
			@(negedge clk);
			compare_field("alu_op", 32'(ALU_NOP), 32'(o_alu_op));
			compare_field("exc", 32'(EXC_NONE), 32'(o_exc));
			compare_field("wreg", 32'd0, 32'(o_wreg));
			compare_field("wmem", 32'd0, 32'(o_wmem));
			compare_field("result_sel", 32'(RES_NONE), 32'(o_result_sel));
			compare_field("alusrc0_sel", 32'd0, 32'(o_alusrc0_sel));
			compare_field("alusrc1_sel", 32'(SRC1_RT), 32'(o_alusrc1_sel));
			compare_field("regdst", 32'(DST_RT), 32'(o_regdst));
			compare_field("sign", 32'd1, 32'(o_sign));
			compare_field("load_type", 32'(LD_NONE), 32'(o_load_type));
			compare_field("store_type", 32'(ST_NONE), 32'(o_store_type));
			compare_field("i_bj", 32'd0, 32'(o_i_bj));
			compare_field("i_b", 32'd0, 32'(o_i_b));
			compare_field("pc_target_sel", 32'd0, 32'(o_pc_target_sel));
			compare_field("pc_branch", 32'd0, o_pc_branch);
			end
		close_test();
	endtask

	// result is due one rising edge after the drive
	task automatic run_vector(input int idx);
		logic [31:0] exp_src0;
		inst = vecs[idx][0];
		rs_data = vecs[idx][1];
		rt_data = vecs[idx][2];
		pc_plus4 = vecs[idx][3];
		cur_name = names[idx];
		test_errs = 0;
		// only the shamt shifts take the first operand from shamt
		exp_src0 = (vecs[idx][4] == 32'(ALU_SLL) || vecs[idx][4] == 32'(ALU_SRL)
			|| vecs[idx][4] == 32'(ALU_SRA)) ? 32'd1 : 32'd0;
		@(negedge clk);
		compare_field("alu_op", vecs[idx][4], 32'(o_alu_op));
		compare_field("exc", vecs[idx][5], 32'(o_exc));
		compare_field("wreg", vecs[idx][6], 32'(o_wreg));
		compare_field("wmem", vecs[idx][7], 32'(o_wmem));
		compare_field("result_sel", vecs[idx][8], 32'(o_result_sel));
		compare_field("alusrc0_sel", exp_src0, 32'(o_alusrc0_sel));
		compare_field("alusrc1_sel", vecs[idx][9], 32'(o_alusrc1_sel));
		compare_field("regdst", vecs[idx][10], 32'(o_regdst));
		compare_field("sign", vecs[idx][11], 32'(o_sign));
		compare_field("load_type", vecs[idx][12], 32'(o_load_type));
		compare_field("store_type", vecs[idx][13], 32'(o_store_type));
		compare_field("pc_target_sel", vecs[idx][14], 32'(o_pc_target_sel));
		compare_field("pc_branch", vecs[idx][15], o_pc_branch);
		close_test();
	endtask

	initial
		begin
		clk = 1'b0;
		rst_n = 1'b0;
		inst = 32'h0c100040;
		rs_data = 32'h5555aaaa;
		rt_data = 32'h5555aaaa;
		pc_plus4 = 32'h00400008;
		cycles = 0;
		cycle_limit = 0;
		pass_count = 0;
		fail_count = 0;
		load_vectors(n_vec, load_ok);
		if (!load_ok || n_vec == 0)
			begin
			$display("no usable test vectors, the run stops here");
			$display("sim failed");
			$finish;
			end
		else
			begin
			cycle_limit = 10 * n_vec + 20;
			check_reset();
			rst_n = 1'b1;
			for (int i = 0; i < n_vec; i++)
				run_vector(i);
			$display("tests: %0d passed, %0d failed", pass_count, fail_count);
			if (fail_count == 0)
				$display("sim passed");
			else
				$display("sim failed");
			$finish;
			end
		end

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ns

module control_unit (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [mips_decode_pkg::XLEN-1:0]   i_inst,
	input  logic [mips_decode_pkg::XLEN-1:0]   i_rs_data,
	input  logic [mips_decode_pkg::XLEN-1:0]   i_rt_data,
	input  logic [mips_decode_pkg::XLEN-1:0]   i_pc_plus4,
	output mips_decode_pkg::alu_op_e           o_alu_op,
	output mips_decode_pkg::exc_flags_t        o_exc,
	output logic                               o_wreg,
	output logic                               o_wmem,
	output mips_decode_pkg::result_sel_e       o_result_sel,
	output logic                               o_alusrc0_sel,
	output mips_decode_pkg::alusrc1_sel_e      o_alusrc1_sel,
	output mips_decode_pkg::regdst_e           o_regdst,
	output logic                               o_sign,
	output mips_decode_pkg::load_type_e        o_load_type,
	output mips_decode_pkg::store_type_e       o_store_type,
	output logic                               o_i_bj,
	output logic                               o_i_b,
	output logic                               o_pc_target_sel,
	output logic [mips_decode_pkg::XLEN-1:0]   o_pc_branch
);
	import mips_decode_pkg::*;

	// instruction fields
	opcode_e             op;
	logic [REG_W-1:0]    rs;
	logic [REG_W-1:0]    rt;
	funct_e              funct;
	logic [OFFSET_W-1:0] offset;
	logic [TARGET_W-1:0] target;

	// decoded controls before the stage register
	alu_op_e         alu_op;
	exc_flags_t      exc;
	logic            wreg;
	logic            wmem;
	result_sel_e     result_sel;
	logic            alusrc0_sel;
	alusrc1_sel_e    alusrc1_sel;
	regdst_e         regdst;
	logic            sign;
	load_type_e      load_type;
	store_type_e     store_type;
	logic            i_bj;
	logic            i_b;
	logic            pc_target_sel;
	logic [XLEN-1:0] pc_branch;

	assign op = opcode_e'(i_inst[31:26]);
	assign rs = i_inst[25:21];
	assign rt = i_inst[20:16];
	assign funct = funct_e'(i_inst[5:0]);
	assign offset = i_inst[OFFSET_W-1:0];
	assign target = i_inst[TARGET_W-1:0];

	alu_op_decoder u_alu_dec (
		.i_op(op), .i_rs(rs), .i_rt(rt), .i_funct(funct),
		.o_alu_op(alu_op), .o_exc(exc)
	);

	datapath_ctrl_decoder u_dp_dec (
		.i_op(op), .i_rt(rt), .i_funct(funct),
		.o_wreg(wreg), .o_wmem(wmem), .o_result_sel(result_sel),
		.o_alusrc0_sel(alusrc0_sel), .o_alusrc1_sel(alusrc1_sel), .o_regdst(regdst),
		.o_sign(sign), .o_load_type(load_type), .o_store_type(store_type)
	);

	branch_unit u_branch (
		.i_op(op), .i_rt(rt), .i_funct(funct), .i_offset(offset), .i_target(target),
		.i_rs_data(i_rs_data), .i_rt_data(i_rt_data), .i_pc_plus4(i_pc_plus4),
		.o_i_bj(i_bj), .o_i_b(i_b), .o_pc_target_sel(pc_target_sel),
		.o_pc_branch(pc_branch)
	);

	decode_stage_reg u_stage (
		.clk(clk), .rst_n(rst_n),
		.i_alu_op(alu_op), .i_exc(exc), .i_wreg(wreg), .i_wmem(wmem),
		.i_result_sel(result_sel), .i_alusrc0_sel(alusrc0_sel),
		.i_alusrc1_sel(alusrc1_sel), .i_regdst(regdst), .i_sign(sign),
		.i_load_type(load_type), .i_store_type(store_type), .i_i_bj(i_bj), .i_i_b(i_b),
		.i_pc_target_sel(pc_target_sel), .i_pc_branch(pc_branch),
		.o_alu_op(o_alu_op), .o_exc(o_exc), .o_wreg(o_wreg), .o_wmem(o_wmem),
		.o_result_sel(o_result_sel), .o_alusrc0_sel(o_alusrc0_sel),
		.o_alusrc1_sel(o_alusrc1_sel), .o_regdst(o_regdst), .o_sign(o_sign),
		.o_load_type(o_load_type), .o_store_type(o_store_type), .o_i_bj(o_i_bj),
		.o_i_b(o_i_b), .o_pc_target_sel(o_pc_target_sel), .o_pc_branch(o_pc_branch)
	);

endmodule

/* hdl/decode_stage_reg.sv */
`timescale 1ns/1ns

module decode_stage_reg (
	input  logic                               clk,
	input  logic                               rst_n,
	input  mips_decode_pkg::alu_op_e           i_alu_op,
	input  mips_decode_pkg::exc_flags_t        i_exc,
	input  logic                               i_wreg,
	input  logic                               i_wmem,
	input  mips_decode_pkg::result_sel_e       i_result_sel,
	input  logic                               i_alusrc0_sel,
	input  mips_decode_pkg::alusrc1_sel_e      i_alusrc1_sel,
	input  mips_decode_pkg::regdst_e           i_regdst,
	input  logic                               i_sign,
	input  mips_decode_pkg::load_type_e        i_load_type,
	input  mips_decode_pkg::store_type_e       i_store_type,
	input  logic                               i_i_bj,
	input  logic                               i_i_b,
	input  logic                               i_pc_target_sel,
	input  logic [mips_decode_pkg::XLEN-1:0]   i_pc_branch,
	output mips_decode_pkg::alu_op_e           o_alu_op,
	output mips_decode_pkg::exc_flags_t        o_exc,
	output logic                               o_wreg,
	output logic                               o_wmem,
	output mips_decode_pkg::result_sel_e       o_result_sel,
	output logic                               o_alusrc0_sel,
	output mips_decode_pkg::alusrc1_sel_e      o_alusrc1_sel,
	output mips_decode_pkg::regdst_e           o_regdst,
	output logic                               o_sign,
	output mips_decode_pkg::load_type_e        o_load_type,
	output mips_decode_pkg::store_type_e       o_store_type,
	output logic                               o_i_bj,
	output logic                               o_i_b,
	output logic                               o_pc_target_sel,
	output logic [mips_decode_pkg::XLEN-1:0]   o_pc_branch
);
	import mips_decode_pkg::*;

	always_ff @(posedge clk)
		begin
		if (!rst_n)
			begin
			o_alu_op <= ALU_NOP;
			o_exc <= EXC_NONE;
			o_wreg <= 1'b0;
			o_wmem <= 1'b0;
			o_result_sel <= RES_NONE;
			o_alusrc0_sel <= 1'b0;
			o_alusrc1_sel <= SRC1_RT;
			o_regdst <= DST_RT;
			// sign extension is the idle level
			o_sign <= 1'b1;
			o_load_type <= LD_NONE;
			o_store_type <= ST_NONE;
			o_i_bj <= 1'b0;
			o_i_b <= 1'b0;
			o_pc_target_sel <= 1'b0;
			o_pc_branch <= '0;
			end
		else
			begin
			o_alu_op <= i_alu_op;
			o_exc <= i_exc;
			o_wreg <= i_wreg;
			o_wmem <= i_wmem;
			o_result_sel <= i_result_sel;
			o_alusrc0_sel <= i_alusrc0_sel;
			o_alusrc1_sel <= i_alusrc1_sel;
			o_regdst <= i_regdst;
			o_sign <= i_sign;
			o_load_type <= i_load_type;
			o_store_type <= i_store_type;
			o_i_bj <= i_i_bj;
			o_i_b <= i_i_b;
			o_pc_target_sel <= i_pc_target_sel;
			o_pc_branch <= i_pc_branch;
			end
		end

	// no write or redirect leaks out of reset
	assert property (@(posedge clk) !rst_n |=> (!o_wreg && !o_wmem && !o_pc_target_sel))
		else $error("decode_stage_reg: side effect one cycle after reset");

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit (
	input  mips_decode_pkg::opcode_e              i_op,
	input  logic [mips_decode_pkg::REG_W-1:0]     i_rt,
	input  mips_decode_pkg::funct_e               i_funct,
	input  logic [mips_decode_pkg::OFFSET_W-1:0]  i_offset,
	input  logic [mips_decode_pkg::TARGET_W-1:0]  i_target,
	input  logic [mips_decode_pkg::XLEN-1:0]      i_rs_data,
	input  logic [mips_decode_pkg::XLEN-1:0]      i_rt_data,
	input  logic [mips_decode_pkg::XLEN-1:0]      i_pc_plus4,
	output logic                                  o_i_bj,
	output logic                                  o_i_b,
	output logic                                  o_pc_target_sel,
	output logic [mips_decode_pkg::XLEN-1:0]      o_pc_branch
);
	import mips_decode_pkg::*;

	logic [XLEN-1:0] pc_target_b;
	logic [XLEN-1:0] pc_target_j;
	logic            rs_neg;
	logic            rs_zero;
	logic            rs_eq_rt;
	logic            is_branch;
	logic            taken;

	// offset counts words
	assign pc_target_b = i_pc_plus4 + {{(XLEN-OFFSET_W-2){i_offset[OFFSET_W-1]}}, i_offset, 2'b00};
	// jump stays inside the current 256 MB region
	assign pc_target_j = {i_pc_plus4[XLEN-1 -: 4], i_target, 2'b00};

	assign rs_neg = i_rs_data[XLEN-1];
	assign rs_zero = (i_rs_data == '0);
	assign rs_eq_rt = (i_rs_data == i_rt_data);

	always_comb
		begin
		is_branch = 1'b1;
		taken = 1'b0;
		case (i_op)
			OP_BEQ: taken = rs_eq_rt;
			OP_BNE: taken = !rs_eq_rt;
			OP_BLEZ: taken = rs_neg || rs_zero;
			OP_BGTZ: taken = !rs_neg && !rs_zero;
			OP_REGIMM:
				begin
				case (i_rt)
					RT_BLTZ, RT_BLTZAL: taken = rs_neg;
					RT_BGEZ, RT_BGEZAL: taken = !rs_neg;
					default: is_branch = 1'b0;
				endcase
				end
			default: is_branch = 1'b0;
		endcase
		end

	always_comb
		begin
		o_i_bj = is_branch;
		o_i_b = is_branch;
		o_pc_target_sel = taken;
		o_pc_branch = is_branch ? pc_target_b : '0;
		if (i_op == OP_J || i_op == OP_JAL)
			begin
			o_i_bj = 1'b1;
			o_pc_target_sel = 1'b1;
			o_pc_branch = pc_target_j;
			end
		else if (i_op == OP_SPECIAL && (i_funct == FN_JR || i_funct == FN_JALR))
			begin
			// register jumps also count as i_b for the fetch side
			o_i_bj = 1'b1;
			o_i_b = 1'b1;
			o_pc_target_sel = 1'b1;
			o_pc_branch = i_rs_data;
			end
		end

	// a redirect only comes from a branch or jump
	always_comb
		begin
		assert final (!o_pc_target_sel || o_i_bj)
			else $error("branch_unit: pc_target_sel without branch/jump");
		end

endmodule

/* hdl/datapath_ctrl_decoder.sv */
`timescale 1ns/1ns

module datapath_ctrl_decoder (
	input  mips_decode_pkg::opcode_e           i_op,
	input  logic [mips_decode_pkg::REG_W-1:0]  i_rt,
	input  mips_decode_pkg::funct_e            i_funct,
	output logic                               o_wreg,
	output logic                               o_wmem,
	output mips_decode_pkg::result_sel_e       o_result_sel,
	output logic                               o_alusrc0_sel,
	output mips_decode_pkg::alusrc1_sel_e      o_alusrc1_sel,
	output mips_decode_pkg::regdst_e           o_regdst,
	output logic                               o_sign,
	output mips_decode_pkg::load_type_e        o_load_type,
	output mips_decode_pkg::store_type_e       o_store_type
);
	import mips_decode_pkg::*;

	always_comb
		begin
		o_wreg = 1'b0;
		o_wmem = 1'b0;
		o_result_sel = RES_NONE;
		o_alusrc0_sel = 1'b0;
		o_alusrc1_sel = SRC1_RT;
		o_regdst = DST_RT;
		o_sign = 1'b1;
		case (i_op)
			// logical immediates are zero extended
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
				begin
				o_wreg = 1'b1;
				o_result_sel = RES_ALU;
				o_alusrc1_sel = SRC1_IMM;
				o_sign = 1'b0;
				end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
				begin
				o_wreg = 1'b1;
				o_result_sel = RES_ALU;
				o_alusrc1_sel = SRC1_IMM;
				end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW:
				begin
				o_wreg = 1'b1;
				o_result_sel = RES_MEM;
				o_alusrc1_sel = SRC1_IMM;
				end
			// address is rs + imm
			OP_SB, OP_SH, OP_SW:
				begin
				o_wmem = 1'b1;
				o_alusrc1_sel = SRC1_IMM;
				end
			OP_JAL:
				begin
				o_wreg = 1'b1;
				o_result_sel = RES_ALU;
				o_regdst = DST_RA;
				end
			OP_REGIMM:
				begin
				if (i_rt == RT_BLTZAL || i_rt == RT_BGEZAL)
					begin
					o_wreg = 1'b1;
					o_result_sel = RES_ALU;
					o_regdst = DST_RA;
					end
				end
			OP_SPECIAL:
				begin
				case (i_funct)
					// shift amount comes from the shamt field
					FN_SLL, FN_SRL, FN_SRA:
						begin
						o_wreg = 1'b1;
						o_result_sel = RES_ALU;
						o_alusrc0_sel = 1'b1;
						o_regdst = DST_RD;
						end
					FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
					FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU, FN_JALR:
						begin
						o_wreg = 1'b1;
						o_result_sel = RES_ALU;
						o_regdst = DST_RD;
						end
					default: ;
				endcase
				end
			default: ;
		endcase
		end

	// access width for the memory stage
	always_comb
		begin
		o_load_type = LD_NONE;
		o_store_type = ST_NONE;
		case (i_op)
			OP_LB: o_load_type = LD_LB;
			OP_LBU: o_load_type = LD_LBU;
			OP_LH: o_load_type = LD_LH;
			OP_LHU: o_load_type = LD_LHU;
			OP_LW: o_load_type = LD_LW;
			OP_SB: o_store_type = ST_SB;
			OP_SH: o_store_type = ST_SH;
			OP_SW: o_store_type = ST_SW;
			default: ;
		endcase
		end

endmodule

/* hdl/alu_op_decoder.sv */
`timescale 1ns/1ns

module alu_op_decoder (
	input  mips_decode_pkg::opcode_e                i_op,
	input  logic [mips_decode_pkg::REG_W-1:0]       i_rs,
	input  logic [mips_decode_pkg::REG_W-1:0]       i_rt,
	input  mips_decode_pkg::funct_e                 i_funct,
	output mips_decode_pkg::alu_op_e                o_alu_op,
	output mips_decode_pkg::exc_flags_t             o_exc
);
	import mips_decode_pkg::*;

	always_comb
		begin
		o_alu_op = ALU_NOP;
		o_exc = EXC_NONE;
		case (i_op)
			OP_J, OP_BEQ, OP_BNE, OP_PREF: o_alu_op = ALU_NOP;
			OP_JAL: o_alu_op = ALU_JALR;
			// rt must be zero for these two
			OP_BLEZ, OP_BGTZ: o_exc.ri = |i_rt;
			OP_ADDI: o_alu_op = ALU_ADDI;
			OP_ADDIU: o_alu_op = ALU_ADDIU;
			OP_SLTI: o_alu_op = ALU_SLTI;
			OP_SLTIU: o_alu_op = ALU_SLTIU;
			OP_ANDI: o_alu_op = ALU_ANDI;
			OP_ORI: o_alu_op = ALU_ORI;
			OP_XORI: o_alu_op = ALU_XORI;
			OP_LUI:
				begin
				o_alu_op = ALU_LU;
				o_exc.ri = |i_rs;
				end
			OP_LB: o_alu_op = ALU_LB;
			OP_LBU: o_alu_op = ALU_LBU;
			OP_LH: o_alu_op = ALU_LH;
			OP_LHU: o_alu_op = ALU_LHU;
			OP_LW: o_alu_op = ALU_LW;
			OP_SB: o_alu_op = ALU_SB;
			OP_SH: o_alu_op = ALU_SH;
			OP_SW: o_alu_op = ALU_SW;
			// no cp0 moves or eret in this core
			OP_COP0: o_exc.ri = 1'b1;
			OP_COP1: o_exc.cpu = 1'b1;
			OP_REGIMM:
				begin
				case (i_rt)
					RT_BLTZ, RT_BGEZ: o_alu_op = ALU_NOP;
					RT_BLTZAL, RT_BGEZAL: o_alu_op = ALU_JALR;
					default: o_exc.ri = 1'b1;
				endcase
				end
			OP_SPECIAL:
				begin
				case (i_funct)
					FN_SLL: o_alu_op = ALU_SLL;
					FN_SRL: o_alu_op = ALU_SRL;
					FN_SRA: o_alu_op = ALU_SRA;
					FN_SLLV: o_alu_op = ALU_SLLV;
					FN_SRLV: o_alu_op = ALU_SRLV;
					FN_SRAV: o_alu_op = ALU_SRAV;
					FN_JR, FN_SYNC: o_alu_op = ALU_NOP;
					FN_JALR: o_alu_op = ALU_JALR;
					FN_SYSCALL: o_exc.sys = 1'b1;
					FN_BREAK: o_exc.bp = 1'b1;
					FN_ADD: o_alu_op = ALU_ADD;
					FN_ADDU: o_alu_op = ALU_ADDU;
					FN_SUB: o_alu_op = ALU_SUB;
					FN_SUBU: o_alu_op = ALU_SUBU;
					FN_AND: o_alu_op = ALU_AND;
					FN_OR: o_alu_op = ALU_OR;
					FN_XOR: o_alu_op = ALU_XOR;
					FN_NOR: o_alu_op = ALU_NOR;
					FN_SLT: o_alu_op = ALU_SLT;
					FN_SLTU: o_alu_op = ALU_SLTU;
					// hi/lo, traps and movz/movn end up here
					default: o_exc.ri = 1'b1;
				endcase
				end
			default: o_exc.ri = 1'b1;
		endcase
		end

	// causes are exclusive across every decode path
	always_comb
		begin
		assert final ($onehot0(o_exc))
			else $error("alu_op_decoder: more than one exception flag set");
		end

endmodule

/* hdl/mips_decode_pkg.sv */
package mips_decode_pkg;

	localparam int XLEN     = 32;
	localparam int REG_W    = 5;
	localparam int OFFSET_W = 16;
	localparam int TARGET_W = 26;

	// primary opcodes, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
		OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
		OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
		OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
		OP_COP0    = 6'h10, OP_COP1   = 6'h11,
		OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
		OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b,
		OP_PREF    = 6'h33
	} opcode_e;

	// SPECIAL function field, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA     = 6'h03, FN_SLLV  = 6'h04,
		FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR      = 6'h08, FN_JALR  = 6'h09,
		FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d, FN_SYNC = 6'h0f,
		FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB     = 6'h22, FN_SUBU  = 6'h23,
		FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR     = 6'h26, FN_NOR   = 6'h27,
		FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
	} funct_e;

	// REGIMM branches are selected by the rt field
	typedef enum logic [4:0] {
		RT_BLTZ   = 5'h00,
		RT_BGEZ   = 5'h01,
		RT_BLTZAL = 5'h10,
		RT_BGEZAL = 5'h11
	} regimm_rt_e;

	typedef enum logic [7:0] {
		ALU_NOP  = 8'h00, ALU_ADD   = 8'h01, ALU_ADDU  = 8'h02, ALU_SUB   = 8'h03,
		ALU_SUBU = 8'h04, ALU_AND   = 8'h05, ALU_OR    = 8'h06, ALU_XOR   = 8'h07,
		ALU_NOR  = 8'h08, ALU_SLT   = 8'h09, ALU_SLTU  = 8'h0a, ALU_SLL   = 8'h0b,
		ALU_SRL  = 8'h0c, ALU_SRA   = 8'h0d, ALU_SLLV  = 8'h0e, ALU_SRLV  = 8'h0f,
		ALU_SRAV = 8'h10, ALU_ADDI  = 8'h11, ALU_ADDIU = 8'h12, ALU_SLTI  = 8'h13,
		ALU_SLTIU = 8'h14, ALU_ANDI = 8'h15, ALU_ORI   = 8'h16, ALU_XORI  = 8'h17,
		ALU_LU   = 8'h18, ALU_LB    = 8'h19, ALU_LBU   = 8'h1a, ALU_LH    = 8'h1b,
		ALU_LHU  = 8'h1c, ALU_LW    = 8'h1d, ALU_SB    = 8'h1e, ALU_SH    = 8'h1f,
		ALU_SW   = 8'h20,
		// link address, PC + 8
		ALU_JALR = 8'h21
	} alu_op_e;

	typedef enum logic [1:0] {
		RES_NONE = 2'b00,
		RES_ALU  = 2'b01,
		RES_MEM  = 2'b10
	} result_sel_e;

	typedef enum logic [1:0] {
		SRC1_RT  = 2'b00,
		SRC1_IMM = 2'b11
	} alusrc1_sel_e;

	// DST_RA is register 31
	typedef enum logic [1:0] {
		DST_RT = 2'b00,
		DST_RD = 2'b01,
		DST_RA = 2'b10
	} regdst_e;

	typedef enum logic [3:0] {
		LD_NONE = 4'h0, LD_LB = 4'h1, LD_LBU = 4'h2, LD_LH = 4'h3, LD_LHU = 4'h4, LD_LW = 4'h5
	} load_type_e;

	typedef enum logic [3:0] {
		ST_NONE = 4'h0, ST_SB = 4'h1, ST_SH = 4'h2, ST_SW = 4'h3
	} store_type_e;

	typedef struct packed {
		logic ri;
		logic sys;
		logic bp;
		logic cpu;
	} exc_flags_t;

	localparam exc_flags_t EXC_NONE = '0;

endpackage
